// ==== Bender.yml ====
package:
  name: vcu

sources:
  - files:
      - src/vcu_data_pkg.sv
      - src/vcu_insn_pkg.sv
      - src/vcu_sequencer.sv
      - src/acc_fetch.sv
      - src/row_fifo.sv
      - src/lane_program.sv
      - src/vcu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/vcu_tb.sv

// ==== sim/vcu_tb_tests.svh ====
//////////////////////////////
// reference model

function automatic longint clip(input longint v, input longint lo, input longint hi);
    if (v > hi)
        return hi;
    if (v < lo)
        return lo;
    return v;
endfunction

// requantize, run the program, quantize to int8
function automatic vcu_data_pkg::out_row_t expect_row(
    input vcu_data_pkg::acc_row_t a,
    input int                     shift,
    input int                     paddr,
    input int                     plen
);
    vcu_data_pkg::out_row_t r;
    longint                 v;
    for (int l = 0; l < vcu_data_pkg::LANES; l++)
    begin
        v = clip(longint'($signed(a[l])) >>> shift, -32768, 32767);
        for (int k = 0; k < plen; k++)
        begin
            case (prog_ref[(paddr + k) % 1024])
                vcu_data_pkg::OP_ADD:
                    v = v + longint'($signed(cfg_ref.add));
                vcu_data_pkg::OP_MUL:
                    v = (v * longint'($signed(cfg_ref.mul))) >>> 8;
                vcu_data_pkg::OP_MAX:
                    if (longint'($signed(cfg_ref.clamp)) > v)
                        v = longint'($signed(cfg_ref.clamp));
                default:
                    v = v;
            endcase
            v = clip(v, -32768, 32767);
        end
        r[l] = 8'(clip(v, -128, 127));
    end
    return r;
endfunction

//////////////////////////////
// stimulus helpers

// reserved opcode bits get random junk
task automatic write_op(input int addr, input vcu_data_pkg::op_t op);
    @(posedge clk);
    opc_wr <= '{en: 1'b1, addr: 10'(addr), data: '{rsvd: 14'(rand_bits(14)), op: op}};
    @(posedge clk);
    opc_wr.en <= 1'b0;
    prog_ref[addr] = op;
endtask

task automatic fill_rows(input int base, input int n, input int bits);
    for (int r = 0; r < n; r++)
        for (int l = 0; l < vcu_data_pkg::LANES; l++)
            acc_mem[12'(base + r)][l] = rand_acc(bits);
endtask

// four-phase handshake with ack checked against req
task automatic run_insn(input vcu_insn_pkg::insn_t i, input int rows, input int limit);
    int n;
    int base;
    base = wr_count;
    n    = 0;
    @(posedge clk);
    insn     <= i;
    insn_req <= 1'b1;
    @(negedge clk);
    while (!insn_ack && n < limit)
    begin
        @(negedge clk);
        n++;
    end
    checks++;
    if (!insn_ack)
    begin
        errors++;
        $display("insn_ack never rose within %0d cycles", limit);
    end
    else if (wr_count - base != rows)
    begin
        errors++;
        $display("[ERROR] row writes at insn_ack: got 0x%0h, expected 0x%0h",
                 wr_count - base, rows);
    end
    repeat (2)
    begin
        @(negedge clk);
        check_ack("insn_ack", insn_ack, 1'b1);
    end
    @(posedge clk);
    insn_req <= 1'b0;
    @(negedge clk);
    check_ack("insn_ack", insn_ack, 1'b1);
    @(negedge clk);
    check_ack("insn_ack", insn_ack, 1'b0);
endtask

task automatic apply_config(input int add, input int mul, input int clamp);
    vcu_insn_pkg::insn_t i;
    i             = '0;
    i.kind        = vcu_insn_pkg::KIND_CONFIG;
    i.add_const   = 16'(add);
    i.mul_const   = 16'(mul);
    i.clamp_const = 16'(clamp);
    i.pad         = 23'(rand_bits(23));
    run_insn(i, 0, 20);
    cfg_ref = '{add: 16'(add), mul: 16'(mul), clamp: 16'(clamp)};
endtask

// compute ignores the const fields so they carry noise
task automatic run_compute(input int src, input int dst, input int rows,
                           input int paddr, input int plen, input int shift);
    vcu_insn_pkg::insn_t i;
    i             = '0;
    i.kind        = vcu_insn_pkg::KIND_COMPUTE;
    i.src_addr    = 12'(src);
    i.dst_addr    = 12'(dst);
    i.row_count   = 12'(rows);
    i.prog_addr   = 10'(paddr);
    i.prog_len    = 5'(plen);
    i.shift       = 5'(shift);
    i.add_const   = 16'(rand_bits(16));
    i.clamp_const = 16'(rand_bits(16));
    for (int r = 0; r < rows; r++)
        out_mem[12'(dst + r)] = 'x;
    run_insn(i, rows, rows * (plen + 8) + 20);
    for (int r = 0; r < rows; r++)
        check_out_row(12'(dst + r), out_mem[12'(dst + r)],
                      expect_row(acc_mem[12'(src + r)], shift, paddr, plen));
endtask

//////////////////////////////
// directed tests

task automatic reset_defaults();
    @(negedge clk);
    check_ack("insn_ack", insn_ack, 1'b0);
    check_ack("out_wr.en", out_wr.en, 1'b0);
    check_ack("acc_rd.en", acc_rd.en, 1'b0);
    write_op(0, vcu_data_pkg::OP_NOP);
    fill_rows(0, 4, 9);
    run_compute(0, 0, 4, 0, 1, 0);
    // identity under the reset constants
    write_op(1, vcu_data_pkg::OP_MUL);
    write_op(2, vcu_data_pkg::OP_MAX);
    write_op(3, vcu_data_pkg::OP_ADD);
    run_compute(0, 8, 4, 1, 3, 0);
endtask

task automatic config_single_row();
    apply_config(300, 200, -1000);
    write_op(10, vcu_data_pkg::OP_ADD);
    write_op(11, vcu_data_pkg::OP_MUL);
    write_op(12, vcu_data_pkg::OP_MAX);
    fill_rows(64, 1, 12);
    run_compute(64, 'h123, 1, 10, 3, 3);
endtask

task automatic multi_row_lfsr();
    int sh [3] = '{8, 17, 23};
    apply_config(-20, 96, -60);
    write_op(200, vcu_data_pkg::OP_ADD);
    write_op(201, vcu_data_pkg::OP_MUL);
    write_op(202, vcu_data_pkg::OP_MAX);
    write_op(203, vcu_data_pkg::OP_NOP);
    fill_rows(512, 12, 32);
    for (int k = 0; k < 3; k++)
        run_compute(512, 1024 + 16 * k, 12, 200, 4, sh[k]);
endtask

task automatic saturation();
    apply_config(30000, 512, -20000);
    write_op(300, vcu_data_pkg::OP_ADD);
    write_op(301, vcu_data_pkg::OP_MUL);
    write_op(302, vcu_data_pkg::OP_MAX);
    acc_mem[700] = {32'sh7fffffff, 32'sh80000000, 32'sd40000, -32'sd40000,
                    32'sd32767, -32'sd32768, 32'sd127, -32'sd129};
    acc_mem[701] = {32'sd100000, -32'sd100000, 32'sd65535, -32'sd65536,
                    32'sd200, -32'sd200, 32'sd0, -32'sd1};
    run_compute(700, 2000, 2, 300, 3, 0);
endtask

// second run reuses prog_addr after the RAM was rewritten
task automatic back_to_back();
    apply_config(5, 384, -50);
    write_op(100, vcu_data_pkg::OP_MAX);
    write_op(101, vcu_data_pkg::OP_ADD);
    fill_rows(800, 3, 10);
    run_compute(800, 2100, 3, 100, 2, 1);
    apply_config(-7, 128, 10);
    write_op(100, vcu_data_pkg::OP_MUL);
    write_op(101, vcu_data_pkg::OP_ADD);
    write_op(102, vcu_data_pkg::OP_MUL);
    run_compute(800, 2200, 3, 100, 3, 1);
endtask

// ==== sim/vcu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcu_tb;

    // rows times (prog_len + 8) summed over all tests, plus margin
    localparam int WATCH_CYCLES = 4*9 + 4*11 + 1*11 + 36*12 + 2*11 + 3*10 + 3*11 + 1000;

    logic                     clk;
    logic                     rst;
    vcu_insn_pkg::insn_t      insn;
    logic                     insn_req;
    logic                     insn_ack;
    vcu_data_pkg::acc_rd_t    acc_rd;
    vcu_data_pkg::acc_row_t   acc_data;
    vcu_data_pkg::opc_wr_t    opc_wr;
    vcu_data_pkg::out_wr_t    out_wr;

    // memory models
    vcu_data_pkg::acc_row_t   acc_mem [2**vcu_data_pkg::ACC_ADDR_W];
    vcu_data_pkg::out_row_t   out_mem [2**vcu_data_pkg::OUT_ADDR_W];
    int                       wr_count;

    // reference state for the model
    vcu_data_pkg::op_t        prog_ref [2**vcu_data_pkg::OPC_ADDR_W];
    vcu_insn_pkg::const_set_t cfg_ref;

    logic [31:0]              lfsr_q;
    int                       errors;
    int                       checks;

    vcu_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .insn     (insn),
        .insn_req (insn_req),
        .insn_ack (insn_ack),
        .acc_rd   (acc_rd),
        .acc_data (acc_data),
        .opc_wr   (opc_wr),
        .out_wr   (out_wr)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // accumulator memory, data one cycle after en
    always @(posedge clk)
    begin
        if (acc_rd.en)
            acc_data <= acc_mem[acc_rd.addr];
    end

    // output memory capture
    always @(posedge clk)
    begin
        if (out_wr.en)
        begin
            out_mem[out_wr.addr] <= out_wr.data;
            wr_count             <= wr_count + 1;
        end
    end

    //////////////////////////////
    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // sign extended random value of the given width
    function automatic vcu_data_pkg::acc_t rand_acc(input int bits);
        logic [31:0] v;
        v = rand_bits(bits);
        if (bits < 32 && v[bits-1])
            v = v | (32'hffff_ffff << bits);
        return v;
    endfunction

    //////////////////////////////
    task automatic check_out_row(
        input int                     addr,
        input vcu_data_pkg::out_row_t got,
        input vcu_data_pkg::out_row_t exp
    );
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] out_mem[0x%03h]: got 0x%h, expected 0x%h", addr, got, exp);
        end
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    `include "vcu_tb_tests.svh"

    // watchdog
    initial
    begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCH_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        lfsr_q   = 32'h2842ebcd;
        errors   = 0;
        checks   = 0;
        wr_count = 0;
        cfg_ref  = '{add: 16'sh0000, mul: 16'sh0100, clamp: 16'sh8000};
        rst      = 1'b1;
        insn     = '0;
        insn_req = 1'b0;
        opc_wr   = '0;
        acc_data = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        reset_defaults();
        config_single_row();
        multi_row_lfsr();
        saturation();
        back_to_back();

        $display("closing: %0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/acc_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     job_start,
    input  vcu_insn_pkg::fetch_job_t fetch_job,
    output vcu_data_pkg::acc_rd_t    acc_rd,
    input  vcu_data_pkg::acc_row_t   acc_data,
    output logic                     row_valid,
    input  logic                     row_ready,
    output vcu_data_pkg::lane_row_t  row
);

    logic [vcu_data_pkg::ACC_ADDR_W-1:0] addr_q;
    logic [vcu_insn_pkg::ROW_CNT_W-1:0]  rows_left;
    logic [vcu_insn_pkg::SHIFT_W-1:0]    shift_q;
    logic                                pending;
    logic                                full;
    logic                                rd_en;
    vcu_data_pkg::lane_row_t             requant;
    vcu_data_pkg::lane_row_t             row_q;

    // at most one read in flight, none while a row is parked
    assign rd_en     = (rows_left != 0) && !pending && !full;
    assign acc_rd    = '{en: rd_en, addr: addr_q};
    assign row_valid = full;
    assign row       = row_q;

    // arithmetic shift then clip to int16
    always_comb
    begin
        for (int i = 0; i < vcu_data_pkg::LANES; i++)
        begin
            requant[i] = vcu_data_pkg::sat_lane($signed(acc_data[i]) >>> shift_q);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rows_left <= '0;
            pending   <= 1'b0;
            full      <= 1'b0;
        end
        else
        begin
            if (job_start)
                rows_left <= fetch_job.row_count;
            else if (rd_en)
                rows_left <= rows_left - 1'b1;
            pending <= rd_en;
            if (pending)
                full <= 1'b1;
            else if (full && row_ready)
                full <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (job_start)
        begin
            addr_q  <= fetch_job.src_addr;
            shift_q <= fetch_job.shift;
        end
        else if (rd_en)
        begin
            addr_q <= addr_q + 1'b1;
        end
        // memory data arrives the cycle after en
        if (pending)
            row_q <= requant;
    end

endmodule

`default_nettype wire

// ==== src/lane_program.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_program (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     job_start,
    input  vcu_insn_pkg::lane_job_t  lane_job,
    input  vcu_insn_pkg::const_set_t consts,
    input  vcu_data_pkg::opc_wr_t    opc_wr,
    input  logic                     row_valid,
    output logic                     row_ready,
    input  vcu_data_pkg::lane_row_t  row,
    output vcu_data_pkg::out_wr_t    out_wr,
    output logic                     row_written
);

    typedef enum logic [1:0] {
        L_IDLE,
        L_EXEC,
        L_WRITE
    } state_t;

    state_t                              state;
    vcu_data_pkg::opcode_t               opc_mem [2**vcu_data_pkg::OPC_ADDR_W];
    vcu_data_pkg::opcode_t               opc_rd;
    logic [vcu_data_pkg::OPC_ADDR_W-1:0] rd_addr;
    logic [vcu_data_pkg::OPC_ADDR_W-1:0] pc_q;
    logic [vcu_data_pkg::OPC_ADDR_W-1:0] prog_addr_q;
    logic [vcu_data_pkg::PROG_LEN_W-1:0] prog_len_q;
    logic [vcu_data_pkg::PROG_LEN_W-1:0] step_q;
    logic [vcu_data_pkg::OUT_ADDR_W-1:0] dst_q;
    logic                                pop;
    vcu_data_pkg::lane_row_t             work_q;
    vcu_data_pkg::lane_row_t             work_nxt;
    vcu_data_pkg::out_row_t              out_data;

    // one lane, one opcode; every result clipped to int16
    function automatic vcu_data_pkg::lane_t apply_op(
        input vcu_data_pkg::op_t        op,
        input vcu_data_pkg::lane_t      v,
        input vcu_insn_pkg::const_set_t c
    );
        logic signed [31:0] wide;
        logic signed [31:0] k;
        wide = v;
        case (op)
            vcu_data_pkg::OP_ADD:
            begin
                k    = c.add;
                wide = wide + k;
            end
            vcu_data_pkg::OP_MUL:
            begin
                // Q8 multiply
                k    = c.mul;
                wide = (wide * k) >>> 8;
            end
            vcu_data_pkg::OP_MAX:
            begin
                k = c.clamp;
                if (k > wide)
                    wide = k;
            end
            default:
            begin
                wide = v;
            end
        endcase
        return vcu_data_pkg::sat_lane(wide);
    endfunction

    assign row_ready   = (state == L_IDLE);
    assign pop         = row_ready && row_valid;
    assign rd_addr     = (state == L_IDLE) ? prog_addr_q : pc_q;
    assign row_written = (state == L_WRITE);
    assign out_wr      = '{en: row_written, addr: dst_q, data: out_data};

    always_comb
    begin
        for (int i = 0; i < vcu_data_pkg::LANES; i++)
        begin
            work_nxt[i] = apply_op(opc_rd.op, work_q[i], consts);
            out_data[i] = vcu_data_pkg::sat_out(work_q[i]);
        end
    end

    //////////////////////////////
    // opcode RAM, one cycle read
    always_ff @(posedge clk)
    begin
        if (opc_wr.en)
            opc_mem[opc_wr.addr] <= opc_wr.data;
        opc_rd <= opc_mem[rd_addr];
    end

    //////////////////////////////
    // per row: pop, prog_len ops, write
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= L_IDLE;
            step_q <= '0;
        end
        else
        begin
            case (state)
                L_IDLE:
                begin
                    if (pop)
                    begin
                        step_q <= '0;
                        state  <= L_EXEC;
                    end
                end
                L_EXEC:
                begin
                    step_q <= step_q + 1'b1;
                    if (step_q == prog_len_q - 1'b1)
                        state <= L_WRITE;
                end
                default:
                begin
                    state <= L_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (job_start)
        begin
            prog_addr_q <= lane_job.prog_addr;
            prog_len_q  <= lane_job.prog_len;
            dst_q       <= lane_job.dst_addr;
        end
        else if (state == L_WRITE)
        begin
            dst_q <= dst_q + 1'b1;
        end
        if (pop)
        begin
            work_q <= row;
            pc_q   <= prog_addr_q + 1'b1;
        end
        else if (state == L_EXEC)
        begin
            work_q <= work_nxt;
            pc_q   <= pc_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/row_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  vcu_data_pkg::lane_row_t in_row,
    output logic                    out_valid,
    input  logic                    out_ready,
    output vcu_data_pkg::lane_row_t out_row
);

    vcu_data_pkg::lane_row_t             mem [vcu_data_pkg::FIFO_DEPTH];
    logic [vcu_data_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [vcu_data_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [vcu_data_pkg::FIFO_CNT_W-1:0] count;
    logic                                push;
    logic                                pop;

    assign in_ready  = (count != vcu_data_pkg::FIFO_CNT_W'(vcu_data_pkg::FIFO_DEPTH));
    assign out_valid = (count != 0);
    assign out_row   = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_row;
    end

    // power of two depth, pointers wrap on their own
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/vcu_data_pkg.sv ====
`default_nettype none

package vcu_data_pkg;

    localparam int LANES      = 8;
    localparam int ACC_ADDR_W = 12;
    localparam int OUT_ADDR_W = 12;
    localparam int OPC_ADDR_W = 10;
    localparam int PROG_LEN_W = 5;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // element types, one per pipeline stage
    typedef logic signed [31:0] acc_t;
    typedef logic signed [15:0] lane_t;
    typedef logic signed [7:0]  out_t;

    typedef acc_t  [LANES-1:0] acc_row_t;
    typedef lane_t [LANES-1:0] lane_row_t;
    typedef out_t  [LANES-1:0] out_row_t;

    typedef enum logic [1:0] {
        OP_NOP = 2'd0,
        OP_ADD = 2'd1,
        OP_MUL = 2'd2,
        OP_MAX = 2'd3
    } op_t;

    // upper bits reserved
    typedef struct packed {
        logic [13:0] rsvd;
        op_t         op;
    } opcode_t;

    typedef struct packed {
        logic                  en;
        logic [ACC_ADDR_W-1:0] addr;
    } acc_rd_t;

    typedef struct packed {
        logic                  en;
        logic [OUT_ADDR_W-1:0] addr;
        out_row_t              data;
    } out_wr_t;

    typedef struct packed {
        logic                  en;
        logic [OPC_ADDR_W-1:0] addr;
        opcode_t               data;
    } opc_wr_t;

    // clip a wide intermediate into the int16 lane range
    function automatic lane_t sat_lane(input logic signed [31:0] v);
        if (v > 32'sd32767)
            return 16'sh7fff;
        if (v < -32'sd32768)
            return 16'sh8000;
        return v[15:0];
    endfunction

    // final int8 quantize
    function automatic out_t sat_out(input lane_t v);
        if (v > 16'sd127)
            return 8'sh7f;
        if (v < -16'sd128)
            return 8'sh80;
        return v[7:0];
    endfunction

endpackage

`default_nettype wire

// ==== src/vcu_insn_pkg.sv ====
`default_nettype none

package vcu_insn_pkg;

    localparam int ROW_CNT_W = 12;
    localparam int SHIFT_W   = 5;

    typedef enum logic {
        KIND_COMPUTE = 1'b0,
        KIND_CONFIG  = 1'b1
    } insn_kind_t;

    // 128 bit host instruction, msb first
    typedef struct packed {
        insn_kind_t                         kind;
        logic [vcu_data_pkg::ACC_ADDR_W-1:0] src_addr;
        logic [vcu_data_pkg::OUT_ADDR_W-1:0] dst_addr;
        logic [ROW_CNT_W-1:0]               row_count;
        logic [vcu_data_pkg::OPC_ADDR_W-1:0] prog_addr;
        logic [vcu_data_pkg::PROG_LEN_W-1:0] prog_len;
        logic [SHIFT_W-1:0]                 shift;
        vcu_data_pkg::lane_t                add_const;
        vcu_data_pkg::lane_t                mul_const;
        vcu_data_pkg::lane_t                clamp_const;
        logic [22:0]                        pad;
    } insn_t;

    typedef struct packed {
        vcu_data_pkg::lane_t add;
        vcu_data_pkg::lane_t mul;
        vcu_data_pkg::lane_t clamp;
    } const_set_t;

    // mul of 256 is 1.0 in Q8, clamp at int16 minimum
    localparam const_set_t CONST_RESET = '{add: 16'sh0000, mul: 16'sh0100, clamp: 16'sh8000};

    typedef struct packed {
        logic [vcu_data_pkg::ACC_ADDR_W-1:0] src_addr;
        logic [ROW_CNT_W-1:0]               row_count;
        logic [SHIFT_W-1:0]                 shift;
    } fetch_job_t;

    typedef struct packed {
        logic [vcu_data_pkg::OUT_ADDR_W-1:0] dst_addr;
        logic [vcu_data_pkg::OPC_ADDR_W-1:0] prog_addr;
        logic [vcu_data_pkg::PROG_LEN_W-1:0] prog_len;
    } lane_job_t;

endpackage

`default_nettype wire

// ==== src/vcu_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcu_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  vcu_insn_pkg::insn_t      insn,
    input  logic                     insn_req,
    output logic                     insn_ack,
    output logic                     job_start,
    output vcu_insn_pkg::fetch_job_t fetch_job,
    output vcu_insn_pkg::lane_job_t  lane_job,
    output vcu_insn_pkg::const_set_t consts,
    input  logic                     row_written
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_ACK
    } state_t;

    state_t                             state;
    logic [vcu_insn_pkg::ROW_CNT_W-1:0] rows_left;
    logic                               accept;
    logic                               is_config;

    // new instruction only once the previous ack has dropped
    assign accept    = (state == S_IDLE) && insn_req && !insn_ack;
    assign is_config = (insn.kind == vcu_insn_pkg::KIND_CONFIG);

    //////////////////////////////
    // control FSM
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= S_IDLE;
            insn_ack  <= 1'b0;
            job_start <= 1'b0;
            rows_left <= '0;
            consts    <= vcu_insn_pkg::CONST_RESET;
        end
        else
        begin
            job_start <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (accept && is_config)
                    begin
                        consts   <= '{add:   insn.add_const,
                                      mul:   insn.mul_const,
                                      clamp: insn.clamp_const};
                        insn_ack <= 1'b1;
                        state    <= S_ACK;
                    end
                    else if (accept)
                    begin
                        job_start <= 1'b1;
                        rows_left <= insn.row_count;
                        state     <= S_RUN;
                    end
                end
                S_RUN:
                begin
                    // ack only after the last row has landed
                    if (row_written)
                    begin
                        rows_left <= rows_left - 1'b1;
                        if (rows_left == 1)
                        begin
                            insn_ack <= 1'b1;
                            state    <= S_ACK;
                        end
                    end
                end
                S_ACK:
                begin
                    if (!insn_req)
                    begin
                        insn_ack <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // job descriptors, held for the whole run
    always_ff @(posedge clk)
    begin
        if (accept && !is_config)
        begin
            fetch_job <= '{src_addr:  insn.src_addr,
                           row_count: insn.row_count,
                           shift:     insn.shift};
            lane_job  <= '{dst_addr:  insn.dst_addr,
                           prog_addr: insn.prog_addr,
                           prog_len:  insn.prog_len};
        end
    end

endmodule

`default_nettype wire

// ==== src/vcu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  vcu_insn_pkg::insn_t    insn,
    input  logic                   insn_req,
    output logic                   insn_ack,
    output vcu_data_pkg::acc_rd_t  acc_rd,
    input  vcu_data_pkg::acc_row_t acc_data,
    input  vcu_data_pkg::opc_wr_t  opc_wr,
    output vcu_data_pkg::out_wr_t  out_wr
);

    logic                     job_start;
    logic                     row_written;
    vcu_insn_pkg::fetch_job_t fetch_job;
    vcu_insn_pkg::lane_job_t  lane_job;
    vcu_insn_pkg::const_set_t consts;

    // fetch to buffer
    logic                     fetch_valid;
    logic                     fetch_ready;
    vcu_data_pkg::lane_row_t  fetch_row;

    // buffer to lanes
    logic                     lane_valid;
    logic                     lane_ready;
    vcu_data_pkg::lane_row_t  lane_row;

    vcu_sequencer sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .insn        (insn),
        .insn_req    (insn_req),
        .insn_ack    (insn_ack),
        .job_start   (job_start),
        .fetch_job   (fetch_job),
        .lane_job    (lane_job),
        .consts      (consts),
        .row_written (row_written)
    );

    acc_fetch fetch_i (
        .clk       (clk),
        .rst       (rst),
        .job_start (job_start),
        .fetch_job (fetch_job),
        .acc_rd    (acc_rd),
        .acc_data  (acc_data),
        .row_valid (fetch_valid),
        .row_ready (fetch_ready),
        .row       (fetch_row)
    );

    row_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_row    (fetch_row),
        .out_valid (lane_valid),
        .out_ready (lane_ready),
        .out_row   (lane_row)
    );

    lane_program lane_i (
        .clk         (clk),
        .rst         (rst),
        .job_start   (job_start),
        .lane_job    (lane_job),
        .consts      (consts),
        .opc_wr      (opc_wr),
        .row_valid   (lane_valid),
        .row_ready   (lane_ready),
        .row         (lane_row),
        .out_wr      (out_wr),
        .row_written (row_written)
    );

endmodule

`default_nettype wire

// ==== vcu.f ====
+incdir+sim
src/vcu_data_pkg.sv
src/vcu_insn_pkg.sv
src/vcu_sequencer.sv
src/acc_fetch.sv
src/row_fifo.sv
src/lane_program.sv
src/vcu_top.sv
sim/vcu_tb.sv
